//--- Bender.yml
package:
  name: data_proc_unit

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/armIsaPkg.sv
      - source/execPkg.sv
      - source/dpControl.sv
      - source/operandSelect.sv
      - source/shifter.sv
      - source/alu.sv
      - source/dataProcUnit.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - testbench/dataProcUnit_assert.sv
      - testbench/dataProcUnit_tb.sv

//--- sim.f
+incdir+source
source/armIsaPkg.sv
source/execPkg.sv
source/dpControl.sv
source/operandSelect.sv
source/shifter.sv
source/alu.sv
source/dataProcUnit.sv
testbench/dataProcUnit_assert.sv
testbench/dataProcUnit_tb.sv

//--- source/alu.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module alu
  import execPkg::*;
  import armIsaPkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  validE,
  input  logic                  condPass,
  input  execCtrlT              ctrlE,
  input  logic [`EXEC_XLEN-1:0] rnVal,
  input  logic [`EXEC_XLEN-1:0] shiftOut,
  input  logic                  shifterCarryOut,
  input  flagsT                 flagsQ,
  output flagsT                 nextFlags,
  output logic                  resultValid,
  output resultT                result
);

  logic [`EXEC_XLEN-1:0]  addA;
  logic [`EXEC_XLEN-1:0]  addB;
  logic                   addCin;
  logic [`EXEC_XLEN:0]    sum;
  logic                   isArith;
  logic                   isCompare;
  logic [`EXEC_XLEN-1:0]  logicVal;
  logic [`EXEC_XLEN-1:0]  resVal;
  logic [`EXEC_XLEN-1:0]  valueQ;
  logic [`EXEC_REG_W-1:0] rdQ;
  logic                   writeEnQ;

  // Operand setup, subtracts go through inverted input plus carry
  always_comb begin
    addA     = rnVal;
    addB     = shiftOut;
    addCin   = 1'b0;
    isArith  = 1'b1;
    logicVal = '0;
    unique case (ctrlE.op)
      OP_AND, OP_TST: begin
        logicVal = rnVal & shiftOut;
        isArith  = 1'b0;
      end
      OP_EOR, OP_TEQ: begin
        logicVal = rnVal ^ shiftOut;
        isArith  = 1'b0;
      end
      OP_ORR: begin
        logicVal = rnVal | shiftOut;
        isArith  = 1'b0;
      end
      OP_MOV: begin
        logicVal = shiftOut;
        isArith  = 1'b0;
      end
      OP_BIC: begin
        logicVal = rnVal & ~shiftOut;
        isArith  = 1'b0;
      end
      OP_MVN: begin
        logicVal = ~shiftOut;
        isArith  = 1'b0;
      end
      OP_SUB, OP_CMP: begin
        addB   = ~shiftOut;
        addCin = 1'b1;
      end
      OP_RSB: begin
        addA   = ~rnVal;
        addCin = 1'b1;
      end
      OP_ADC: addCin = flagsQ.c;
      OP_SBC: begin
        addB   = ~shiftOut;
        addCin = flagsQ.c; // Borrow is not C
      end
      OP_RSC: begin
        addA   = ~rnVal;
        addCin = flagsQ.c;
      end
      default: addCin = 1'b0; // ADD, CMN
    endcase
  end

  assign sum       = {1'b0, addA} + {1'b0, addB} + {{`EXEC_XLEN{1'b0}}, addCin};
  assign resVal    = isArith ? sum[`EXEC_XLEN-1:0] : logicVal;
  assign isCompare = ctrlE.op inside {OP_TST, OP_TEQ, OP_CMP, OP_CMN};

  always_comb begin
    nextFlags.n = resVal[`EXEC_XLEN-1];
    nextFlags.z = (resVal == '0);
    if (isArith) begin
      nextFlags.c = sum[`EXEC_XLEN];
      nextFlags.v = (addA[`EXEC_XLEN-1] == addB[`EXEC_XLEN-1]) &&
                    (sum[`EXEC_XLEN-1] != addA[`EXEC_XLEN-1]);
    end else begin
      nextFlags.c = shifterCarryOut;
      nextFlags.v = flagsQ.v;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      resultValid <= 1'b0;
      writeEnQ    <= 1'b0;
    end else begin
      resultValid <= validE;
      writeEnQ    <= validE && condPass && !isCompare;
    end
  end

  always_ff @(posedge clk) begin
    valueQ <= resVal;
    rdQ    <= ctrlE.rd;
  end

  assign result = '{value: valueQ, rd: rdQ, writeEn: writeEnQ};

endmodule

//--- source/armIsaPkg.sv
package armIsaPkg;

  // Data-processing opcode, instr[24:21]
  typedef enum logic [3:0] {
    OP_AND = 4'h0,
    OP_EOR = 4'h1,
    OP_SUB = 4'h2,
    OP_RSB = 4'h3,
    OP_ADD = 4'h4,
    OP_ADC = 4'h5,
    OP_SBC = 4'h6,
    OP_RSC = 4'h7,
    OP_TST = 4'h8,
    OP_TEQ = 4'h9,
    OP_CMP = 4'hA,
    OP_CMN = 4'hB,
    OP_ORR = 4'hC,
    OP_MOV = 4'hD,
    OP_BIC = 4'hE,
    OP_MVN = 4'hF
  } dpOpT;

  // instr[6:5]
  typedef enum logic [1:0] {
    SH_LSL = 2'b00,
    SH_LSR = 2'b01,
    SH_ASR = 2'b10,
    SH_ROR = 2'b11
  } shiftKindT;

  // instr[31:28], 4'hF is treated as never
  typedef enum logic [3:0] {
    CC_EQ, CC_NE, CC_CS, CC_CC, CC_MI, CC_PL, CC_VS, CC_VC,
    CC_HI, CC_LS, CC_GE, CC_LT, CC_GT, CC_LE, CC_AL
  } condT;

  typedef enum logic [1:0] {
    CLS_IMM    = 2'b00,
    CLS_RSHIFT = 2'b01,
    CLS_RSR    = 2'b10
  } operandClassT;

endpackage

//--- source/dataProcUnit.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module dataProcUnit
  import execPkg::*;
  import armIsaPkg::*;
(
  input  logic   clk,
  input  logic   rstN,
  input  logic   inValid,
  input  issueT  issue,
  output logic   resultValid,
  output resultT result,
  output flagsT  flags
);

  operandClassT          opClass;
  execCtrlT              ctrlE;
  logic                  validE;
  logic                  condPass;
  flagsT                 flagsQ;
  flagsT                 nextFlags;
  execOpndT              opndE;
  logic [`EXEC_XLEN-1:0] shiftOut;
  logic                  shifterCarryOut;

  assign flags = flagsQ;

  dpControl u_dpControl (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .instr     (issue.instr),
    .opClass   (opClass),
    .nextFlags (nextFlags),
    .ctrlE     (ctrlE),
    .validE    (validE),
    .condPass  (condPass),
    .flagsQ    (flagsQ)
  );

  operandSelect u_operandSelect (
    .clk     (clk),
    .rstN    (rstN),
    .inValid (inValid),
    .issue   (issue),
    .opClass (opClass),
    .opndE   (opndE)
  );

  shifter u_shifter (
    .a               (opndE.a),
    .b               (opndE.b),
    .shiftOut        (shiftOut),
    .isRtype         (ctrlE.opClass == CLS_RSHIFT),
    .isRSRtype       (ctrlE.opClass == CLS_RSR),
    .prevCVflag      ({flagsQ.c, flagsQ.v}),
    .shiftOpCode     (ctrlE.shiftKind),
    .shifterCarryOut (shifterCarryOut)
  );

  alu u_alu (
    .clk             (clk),
    .rstN            (rstN),
    .validE          (validE),
    .condPass        (condPass),
    .ctrlE           (ctrlE),
    .rnVal           (opndE.rnVal),
    .shiftOut        (shiftOut),
    .shifterCarryOut (shifterCarryOut),
    .flagsQ          (flagsQ),
    .nextFlags       (nextFlags),
    .resultValid     (resultValid),
    .result          (result)
  );

endmodule

//--- source/dpControl.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module dpControl
  import execPkg::*;
  import armIsaPkg::*;
(
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  inValid,
  input  logic [`EXEC_XLEN-1:0] instr,
  output operandClassT          opClass,
  input  flagsT                 nextFlags,
  output execCtrlT              ctrlE,
  output logic                  validE,
  output logic                  condPass,
  output flagsT                 flagsQ
);

  execCtrlT ctrlD;

  // Field decode for the incoming instruction
  always_comb begin
    if (instr[25]) begin
      opClass = CLS_IMM;
    end else if (instr[4]) begin
      opClass = CLS_RSR; // Shift amount in Rs
    end else begin
      opClass = CLS_RSHIFT;
    end
  end

  always_comb begin
    ctrlD.op        = dpOpT'(instr[24:21]);
    ctrlD.cond      = condT'(instr[31:28]);
    ctrlD.setFlags  = instr[20];
    ctrlD.opClass   = opClass;
    ctrlD.shiftKind = shiftKindT'(instr[6:5]);
    ctrlD.rd        = instr[15:12];
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      validE <= 1'b0;
      ctrlE  <= '0;
    end else begin
      validE <= inValid;
      if (inValid) begin
        ctrlE <= ctrlD;
      end
    end
  end

  // Condition check in stage 2, sees predecessor's flags
  always_comb begin
    unique case (ctrlE.cond)
      CC_EQ:   condPass = flagsQ.z;
      CC_NE:   condPass = !flagsQ.z;
      CC_CS:   condPass = flagsQ.c;
      CC_CC:   condPass = !flagsQ.c;
      CC_MI:   condPass = flagsQ.n;
      CC_PL:   condPass = !flagsQ.n;
      CC_VS:   condPass = flagsQ.v;
      CC_VC:   condPass = !flagsQ.v;
      CC_HI:   condPass = flagsQ.c && !flagsQ.z;
      CC_LS:   condPass = !flagsQ.c || flagsQ.z;
      CC_GE:   condPass = flagsQ.n == flagsQ.v;
      CC_LT:   condPass = flagsQ.n != flagsQ.v;
      CC_GT:   condPass = !flagsQ.z && (flagsQ.n == flagsQ.v);
      CC_LE:   condPass = flagsQ.z || (flagsQ.n != flagsQ.v);
      CC_AL:   condPass = 1'b1;
      default: condPass = 1'b0; // NV encoding
    endcase
  end

  // NZCV register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flagsQ <= '0;
    end else if (validE && condPass && ctrlE.setFlags) begin
      flagsQ <= nextFlags;
    end
  end

endmodule

//--- source/execPkg.sv
`include "exec_cfg.svh"

package execPkg;
  import armIsaPkg::*;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

  // What the earlier stages hand over
  typedef struct packed {
    logic [`EXEC_XLEN-1:0] instr;
    logic [`EXEC_XLEN-1:0] rnVal;
    logic [`EXEC_XLEN-1:0] rmVal;
    logic [`EXEC_XLEN-1:0] rsVal;
  } issueT;

  // Decoded control for stage 2
  typedef struct packed {
    dpOpT                   op;
    condT                   cond;
    logic                   setFlags;
    operandClassT           opClass;
    shiftKindT              shiftKind;
    logic [`EXEC_REG_W-1:0] rd;
  } execCtrlT;

  // a carries instr or Rs, b the value to shift
  typedef struct packed {
    logic [`EXEC_XLEN-1:0] a;
    logic [`EXEC_XLEN-1:0] b;
    logic [`EXEC_XLEN-1:0] rnVal;
  } execOpndT;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0]  value;
    logic [`EXEC_REG_W-1:0] rd;
    logic                   writeEn;
  } resultT;

endpackage

//--- source/exec_cfg.svh
`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath word
`define EXEC_XLEN 32

// Immediate shift amount, instr[11:7]
`define EXEC_SHAMT_W 5

// Register number, Rn / Rd / Rm / Rs
`define EXEC_REG_W 4

`endif

//--- source/operandSelect.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module operandSelect
  import execPkg::*;
  import armIsaPkg::*;
(
  input  logic         clk,
  input  logic         rstN,
  input  logic         inValid,
  input  issueT        issue,
  input  operandClassT opClass,
  output execOpndT     opndE
);

  logic [7:0]              imm8;
  logic [3:0]              rot;
  logic [2*`EXEC_XLEN-1:0] immRot;
  logic [`EXEC_XLEN-1:0]   immVal;
  execOpndT                opndD;

  assign imm8 = issue.instr[7:0];
  assign rot  = issue.instr[11:8];

  // Rotate right by 2*rot using a doubled copy
  assign immRot = {{(`EXEC_XLEN-8){1'b0}}, imm8, {(`EXEC_XLEN-8){1'b0}}, imm8} >> {rot, 1'b0};
  assign immVal = immRot[`EXEC_XLEN-1:0];

  always_comb begin
    opndD.rnVal = issue.rnVal;
    unique case (opClass)
      CLS_IMM: begin
        opndD.a = issue.instr; // Shifter needs rotate field
        opndD.b = immVal;
      end
      CLS_RSR: begin
        opndD.a = issue.rsVal;
        opndD.b = issue.rmVal;
      end
      default: begin
        opndD.a = issue.instr;
        opndD.b = issue.rmVal;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      opndE <= '0;
    end else if (inValid) begin
      opndE <= opndD;
    end
  end

endmodule

//--- source/shifter.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module shifter
  import execPkg::*;
  import armIsaPkg::*;
(
  input  logic [`EXEC_XLEN-1:0] a,
  input  logic [`EXEC_XLEN-1:0] b,
  output logic [`EXEC_XLEN-1:0] shiftOut,
  input  logic                  isRtype,
  input  logic                  isRSRtype,
  input  logic [1:0]            prevCVflag, // [1] C, [0] V
  input  shiftKindT             shiftOpCode,
  output logic                  shifterCarryOut
);

  logic [`EXEC_SHAMT_W-1:0] shamtImm;
  logic [7:0]               shamtReg;
  logic [2*`EXEC_XLEN-1:0]  rotTmp;
  logic                     oldC;

  assign shamtImm = a[11:7];
  assign shamtReg = a[7:0]; // Low byte of Rs
  assign oldC     = prevCVflag[1];

  always_comb begin
    shiftOut        = b;
    shifterCarryOut = oldC;
    rotTmp          = '0;
    if (isRtype) begin
      unique case (shiftOpCode)
        SH_LSL: begin
          shiftOut = b << shamtImm;
          if (shamtImm != '0) begin
            shifterCarryOut = b[`EXEC_XLEN - shamtImm];
          end
        end
        SH_LSR: begin
          if (shamtImm == '0) begin // LSR #32
            shiftOut        = '0;
            shifterCarryOut = b[`EXEC_XLEN-1];
          end else begin
            shiftOut        = b >> shamtImm;
            shifterCarryOut = b[shamtImm - 1];
          end
        end
        SH_ASR: begin
          if (shamtImm == '0) begin // ASR #32
            shiftOut        = {`EXEC_XLEN{b[`EXEC_XLEN-1]}};
            shifterCarryOut = b[`EXEC_XLEN-1];
          end else begin
            shiftOut        = $signed(b) >>> shamtImm;
            shifterCarryOut = b[shamtImm - 1];
          end
        end
        SH_ROR: begin
          if (shamtImm == '0) begin // RRX
            shiftOut        = {oldC, b[`EXEC_XLEN-1:1]};
            shifterCarryOut = b[0];
          end else begin
            rotTmp          = {b, b} >> shamtImm;
            shiftOut        = rotTmp[`EXEC_XLEN-1:0];
            shifterCarryOut = b[shamtImm - 1];
          end
        end
      endcase
    end else if (isRSRtype) begin
      if (shamtReg != 8'd0) begin // Zero amount keeps b and old C
        unique case (shiftOpCode)
          SH_LSL: begin
            if (shamtReg < `EXEC_XLEN) begin
              shiftOut        = b << shamtReg;
              shifterCarryOut = b[`EXEC_XLEN - shamtReg];
            end else begin
              shiftOut        = '0;
              shifterCarryOut = (shamtReg == `EXEC_XLEN) ? b[0] : 1'b0;
            end
          end
          SH_LSR: begin
            if (shamtReg < `EXEC_XLEN) begin
              shiftOut        = b >> shamtReg;
              shifterCarryOut = b[shamtReg - 1];
            end else begin
              shiftOut        = '0;
              shifterCarryOut = (shamtReg == `EXEC_XLEN) ? b[`EXEC_XLEN-1] : 1'b0;
            end
          end
          SH_ASR: begin
            if (shamtReg < `EXEC_XLEN) begin
              shiftOut        = $signed(b) >>> shamtReg;
              shifterCarryOut = b[shamtReg - 1];
            end else begin
              shiftOut        = {`EXEC_XLEN{b[`EXEC_XLEN-1]}};
              shifterCarryOut = b[`EXEC_XLEN-1];
            end
          end
          SH_ROR: begin
            if (shamtReg[4:0] == 5'd0) begin // Multiple of 32
              shifterCarryOut = b[`EXEC_XLEN-1];
            end else begin
              rotTmp          = {b, b} >> shamtReg[4:0];
              shiftOut        = rotTmp[`EXEC_XLEN-1:0];
              shifterCarryOut = b[shamtReg[4:0] - 1];
            end
          end
        endcase
      end
    end else begin
      // Immediate already rotated upstream
      shifterCarryOut = (a[11:8] == 4'd0) ? oldC : b[`EXEC_XLEN-1];
    end
  end

endmodule

//--- testbench/dataProcUnit_assert.sv
`timescale 1ns/10ps

module dataProcUnit_assert
  import execPkg::*;
(
  input logic   clk,
  input logic   rstN,
  input logic   inValid,
  input logic   resultValid,
  input resultT result,
  input flagsT  flags
);

  int failCount = 0; // Read by the testbench at the end

  resultAfterIssue: assert property (@(posedge clk) disable iff (!rstN)
    inValid |-> ##2 resultValid)
    else begin
      $error("resultValid did not follow inValid after two cycles");
      failCount++;
    end

  issueBeforeResult: assert property (@(posedge clk) disable iff (!rstN)
    resultValid |-> $past(inValid, 2))
    else begin
      $error("resultValid without an instruction issued two cycles earlier");
      failCount++;
    end

  flagsWithResult: assert property (@(posedge clk) disable iff (!rstN)
    $changed(flags) |-> resultValid)
    else begin
      $error("flags changed without resultValid");
      failCount++;
    end

  writeEnWithResult: assert property (@(posedge clk) disable iff (!rstN)
    result.writeEn |-> resultValid)
    else begin
      $error("writeEn high without resultValid");
      failCount++;
    end

endmodule

//--- testbench/dataProcUnit_tb.sv
`timescale 1ns/10ps
`include "exec_cfg.svh"

module dataProcUnit_tb
  import execPkg::*;
;

  typedef struct packed {
    logic [`EXEC_XLEN-1:0] instr;
    logic [`EXEC_XLEN-1:0] rn;
    logic [`EXEC_XLEN-1:0] rm;
    logic [`EXEC_XLEN-1:0] rs;
    logic [`EXEC_XLEN-1:0] value;
    logic                  writeEn;
    flagsT                 flags;
  } vectorT;

  typedef struct packed {
    int     idx;
    int     issueCycle; // Sample count when driven
    vectorT vec;
  } expectT;

  logic   clk = 1'b0;
  logic   rstN;
  logic   inValid;
  issueT  issue;
  logic   resultValid;
  resultT result;
  flagsT  flags;

  vectorT vectors[$];
  expectT expQ[$];
  int     cycleCount = 0;
  int     cycleLimit;
  int     passCount = 0;
  int     errorCount = 0;

  dataProcUnit u_dataProcUnit (
    .clk         (clk),
    .rstN        (rstN),
    .inValid     (inValid),
    .issue       (issue),
    .resultValid (resultValid),
    .result      (result),
    .flags       (flags)
  );

  bind dataProcUnit dataProcUnit_assert u_protocolAssert (
    .clk         (clk),
    .rstN        (rstN),
    .inValid     (inValid),
    .resultValid (resultValid),
    .result      (result),
    .flags       (flags)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // Lines that do not scan as seven hex fields are skipped
  task automatic loadTests(output int count);
    int                    fd;
    int                    got;
    string                 line;
    logic [`EXEC_XLEN-1:0] f0, f1, f2, f3, f4;
    logic [3:0]            we;
    logic [3:0]            nzcv;
    vectorT                v;
    count = 0;
    fd = $fopen("testbench/dataProcUnit_tests.txt", "r");
    if (fd == 0) begin
      $display("Cannot open testbench/dataProcUnit_tests.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        got = $sscanf(line, "%h %h %h %h %h %h %h", f0, f1, f2, f3, f4, we, nzcv);
        if (got == 7) begin
          v = '{instr: f0, rn: f1, rm: f2, rs: f3, value: f4,
                writeEn: we[0], flags: flagsT'(nzcv)};
          vectors.push_back(v);
          count++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic checkResult(input expectT exp);
    bit ok;
    ok = 1'b1;
    assert (cycleCount == exp.issueCycle + 3) else begin // Two DUT cycles after issue
      $display("%0t: result of test %0d came at cycle %0d instead of cycle %0d",
               $time, exp.idx, cycleCount, exp.issueCycle + 3);
      ok = 1'b0;
    end
    assert (result.writeEn === exp.vec.writeEn) else begin
      $display("[FAIL] %0t result.writeEn expected %b got %b",
               $time, exp.vec.writeEn, result.writeEn);
      ok = 1'b0;
    end
    if (exp.vec.writeEn) begin // Value and rd only matter when written
      assert (result.value === exp.vec.value) else begin
        $display("[FAIL] %0t result.value expected %h got %h",
                 $time, exp.vec.value, result.value);
        ok = 1'b0;
      end
      assert (result.rd === exp.vec.instr[15:12]) else begin
        $display("[FAIL] %0t result.rd expected %h got %h",
                 $time, exp.vec.instr[15:12], result.rd);
        ok = 1'b0;
      end
    end
    assert (flags === exp.vec.flags) else begin
      $display("[FAIL] %0t flags expected %b got %b", $time, exp.vec.flags, flags);
      ok = 1'b0;
    end
    if (ok) begin
      $display("test %0d instr %h: ok", exp.idx, exp.vec.instr);
      passCount++;
    end else begin
      $display("test %0d instr %h: mismatch", exp.idx, exp.vec.instr);
      errorCount++;
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge clk) begin : scoreboard
    expectT exp;
    cycleCount = cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles with %0d results outstanding",
               cycleCount, expQ.size());
      $display("Regression failed");
      $finish;
    end else if (rstN) begin
      if (resultValid) begin
        if (expQ.size() == 0) begin
          $display("%0t: resultValid seen with no instruction in flight", $time);
          errorCount++;
        end else begin
          exp = expQ.pop_front();
          checkResult(exp);
        end
      end else if (expQ.size() != 0 && cycleCount > expQ[0].issueCycle + 3) begin
        $display("%0t: resultValid missing for test %0d", $time, expQ[0].idx);
        errorCount++;
        void'(expQ.pop_front());
      end
    end
  end

  initial begin : mainFlow
    int     nTests;
    int     assertFails;
    expectT entry;
    rstN    = 1'b0;
    inValid = 1'b0;
    issue   = '0;
    loadTests(nTests);
    cycleLimit = nTests + 2 + 20; // Latency plus reset and margin
    if (nTests == 0) begin
      $display("No test vectors were loaded");
      $display("Regression failed");
      $finish;
    end else begin
      repeat (16) @(posedge clk);
      rstN <= 1'b1;
      for (int i = 0; i < nTests; i++) begin
        @(posedge clk);
        inValid <= 1'b1;
        issue   <= '{instr: vectors[i].instr, rnVal: vectors[i].rn,
                     rmVal: vectors[i].rm, rsVal: vectors[i].rs};
        entry = '{idx: i, issueCycle: cycleCount, vec: vectors[i]};
        expQ.push_back(entry);
      end
      @(posedge clk);
      inValid <= 1'b0;
      issue   <= '0;
      while (expQ.size() != 0) @(posedge clk);
      repeat (2) @(negedge clk); // Catch stray resultValid
      @(posedge clk);
      assertFails = u_dataProcUnit.u_protocolAssert.failCount;
      $display("Tests %0d, ok %0d, errors %0d, assertion failures %0d",
               nTests, passCount, errorCount, assertFails);
      if (errorCount == 0 && assertFails == 0 && passCount == nTests) begin
        $display("Regression passed");
      end else begin
        $display("Regression failed");
      end
      $finish;
    end
  end

endmodule

//--- testbench/dataProcUnit_tests.txt
# instr rn rm rs value writeEn nzcv, all hex, one instruction per line
# value and rd are checked only when writeEn is 1, nzcv is the flag state after the result
# Immediates with rotate
E3B010FF 00000000 00000000 00000000 000000FF 1 0
E3B024FF 00000000 00000000 00000000 FF000000 1 A
E3913103 00000F00 00000000 00000000 C0000F00 1 A
E3B04000 00000000 00000000 00000000 00000000 1 6
# Register shifted by immediate, then LSR #32, ASR #32, RRX
E1B05205 00000000 F0000001 00000000 00000010 1 2
E1B06426 00000000 12345678 00000000 00123456 1 0
E1B07247 00000000 80000018 00000000 F8000001 1 A
E1B08668 00000000 12345678 00000000 67812345 1 0
E1B09029 00000000 80000000 00000000 00000000 1 6
E1B0A04A 00000000 80000000 00000000 FFFFFFFF 1 A
E1B0B06B 00000000 00000002 00000000 80000001 1 8
# Register shifted by register, amounts 0, 5, 32, 40
E1B01112 00000000 00000123 00000000 00000123 1 0
E1B02132 00000000 000000F0 00000005 00000007 1 2
E1B03112 00000000 00000001 00000020 00000000 1 6
E1B04152 00000000 80000000 00000028 FFFFFFFF 1 A
E1B06172 00000000 000000FF 00000028 FF000000 1 A
# ADCS, ADDS, SUBS, RSCS, CMP
E0B21003 00000005 00000003 00000000 00000009 1 0
E0921003 7FFFFFFF 00000001 00000000 80000000 1 9
E0521003 00000005 00000005 00000000 00000000 1 6
E0F21003 00000003 00000001 00000000 FFFFFFFE 1 8
E1520003 80000000 00000001 00000000 00000000 0 3
# Flag setter followed by EQ, EQ with S, GE, HI
E1520003 00000007 00000007 00000000 00000000 0 6
01A04003 00000000 000000AA 00000000 000000AA 1 6
E1120003 80000000 80000000 00000000 00000000 0 A
01B05003 00000000 00000055 00000000 00000000 0 A
E1520003 00000002 00000005 00000000 00000000 0 8
A0826003 00000010 00000020 00000000 00000000 0 8
E1520003 00000009 00000004 00000000 00000000 0 2
80826003 00000010 00000020 00000000 00000030 1 2
